// File: l1_trigger_config.svh
`ifndef L1_TRIGGER_CONFIG_SVH
`define L1_TRIGGER_CONFIG_SVH

// Array sizes
`define L1_NCHAN            8
`define L1_NBEAMS           2

// Datapath widths
`define L1_SAMPLE_W         12
`define L1_THRESH_W         18
`define L1_COUNT_W          16

// Servo period in wbclk cycles, short for simulation
`define L1_TRIGGER_CLOCKS   64

// Values loaded at reset
`define L1_DEFAULT_THRESH   600
`define L1_DEFAULT_TARGET   8   // Triggers per period
`define L1_DEFAULT_MARGIN   2   // Plus or minus on target
`define L1_DEFAULT_DELTA    50  // Threshold step per period

// Longest channel delay of any beam, in cycles
`define L1_MAX_DELAY        3

`endif

// File: l1_trigger_pkg.sv
`include "l1_trigger_config.svh"

package l1_trigger_pkg;

    // One channel sample, two's complement
    typedef logic signed [`L1_SAMPLE_W-1:0] sample_t;

    // Sum of all channels, grows by log2 of the channel count
    typedef logic signed [`L1_SAMPLE_W+$clog2(`L1_NCHAN)-1:0] beam_sum_t;

    // Threshold on the beam sum magnitude
    typedef logic [`L1_THRESH_W-1:0] thresh_t;

    // Triggers seen in one servo period
    typedef logic [`L1_COUNT_W-1:0] trig_count_t;

    typedef logic [`L1_NBEAMS-1:0] beam_vec_t;  // One bit per beam

    // Channel delays in cycles, one row per beam
    // Beam 0 looks straight up, beam 1 steers across the array
    localparam int unsigned BEAM_DELAY [`L1_NBEAMS][`L1_NCHAN] = '{
        '{0, 0, 0, 0, 0, 0, 0, 0},
        '{0, 0, 1, 1, 2, 2, 3, 3}
    };

endpackage

// File: l1_regmap_pkg.sv
package l1_regmap_pkg;

    typedef logic [21:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // Word index, address bits 5 to 2
    typedef logic [3:0] reg_offset_t;

    localparam int REG_OFFSET_LSB = 2;

    // Control, bit 0 enable, bit 1 restart
    localparam reg_offset_t REG_CTRL    = 4'd0;

    // Servo settings
    localparam reg_offset_t REG_TARGET  = 4'd1;
    localparam reg_offset_t REG_MARGIN  = 4'd2;
    localparam reg_offset_t REG_DELTA   = 4'd3;

    // Per-beam thresholds, writable only with the servo off
    localparam reg_offset_t REG_THRESH0 = 4'd4;
    localparam reg_offset_t REG_THRESH1 = 4'd5;

    // Last completed period, read only
    localparam reg_offset_t REG_COUNT0  = 4'd6;
    localparam reg_offset_t REG_COUNT1  = 4'd7;

    localparam int CTRL_ENABLE_BIT  = 0;
    localparam int CTRL_RESTART_BIT = 1;

endpackage

// File: servo_cfg_if.sv
`include "l1_trigger_config.svh"

interface servo_cfg_if;
    import l1_trigger_pkg::*;

    logic        enable;        // Servo running
    logic        restart;       // One-cycle pulse
    trig_count_t target;
    trig_count_t margin;
    thresh_t     delta;
    beam_vec_t   thresh_wr;     // Per-beam write strobe
    thresh_t     thresh_wdata;

    thresh_t     thresh [`L1_NBEAMS];  // Live thresholds
    trig_count_t count  [`L1_NBEAMS];  // Last completed period

    modport regs (
        output enable, restart, target, margin, delta,
        output thresh_wr, thresh_wdata,
        input  thresh, count
    );

    modport servo (
        input  enable, restart, target, margin, delta,
        input  thresh_wr, thresh_wdata,
        output thresh, count
    );

endinterface

// File: l1_wb_regs.sv
`include "l1_trigger_config.svh"

module l1_wb_regs (
    input  logic                    wbclk,
    input  logic                    reset_delay,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  l1_regmap_pkg::wb_addr_t wb_adr_i,
    input  l1_regmap_pkg::wb_data_t wb_dat_i,
    output logic                    wb_ack_o,
    output l1_regmap_pkg::wb_data_t wb_dat_o,
    servo_cfg_if.regs               cfg
);
    import l1_regmap_pkg::*;
    import l1_trigger_pkg::*;

    logic        ack_q;
    logic        access;      // Active cycle not yet acked
    logic        wr_en;
    reg_offset_t offset;
    wb_data_t    rd_data;
    wb_data_t    dat_q;

    logic        enable_q;
    logic        restart_q;
    trig_count_t target_q;
    trig_count_t margin_q;
    thresh_t     delta_q;

    assign offset = wb_adr_i[REG_OFFSET_LSB +: $bits(reg_offset_t)];
    assign access = wb_cyc_i && wb_stb_i && !ack_q;
    assign wr_en  = access && wb_we_i;

    always_ff @(posedge wbclk) begin
        if (!reset_delay) begin
            ack_q     <= 1'b0;
            enable_q  <= 1'b0;
            restart_q <= 1'b0;
            target_q  <= trig_count_t'(`L1_DEFAULT_TARGET);
            margin_q  <= trig_count_t'(`L1_DEFAULT_MARGIN);
            delta_q   <= thresh_t'(`L1_DEFAULT_DELTA);
        end else begin
            ack_q     <= access;
            restart_q <= 1'b0;  // Pulse lasts one cycle
            if (wr_en) begin
                case (offset)
                    REG_CTRL: begin
                        enable_q  <= wb_dat_i[CTRL_ENABLE_BIT];
                        restart_q <= wb_dat_i[CTRL_RESTART_BIT];
                    end
                    REG_TARGET: target_q <= trig_count_t'(wb_dat_i);
                    REG_MARGIN: margin_q <= trig_count_t'(wb_dat_i);
                    REG_DELTA:  delta_q  <= thresh_t'(wb_dat_i);
                    default: ;  // Thresholds go to the servo, counts are read only
                endcase
            end
        end
    end

    // Threshold strobes land at the ack edge, servo decides if they stick
    always_comb begin
        cfg.thresh_wr    = '0;
        cfg.thresh_wdata = thresh_t'(wb_dat_i);
        if (wr_en) begin
            cfg.thresh_wr[0] = (offset == REG_THRESH0);
            cfg.thresh_wr[1] = (offset == REG_THRESH1);
        end
    end

    always_comb begin
        case (offset)
            REG_CTRL:    rd_data = wb_data_t'(enable_q);  // Restart reads 0
            REG_TARGET:  rd_data = wb_data_t'(target_q);
            REG_MARGIN:  rd_data = wb_data_t'(margin_q);
            REG_DELTA:   rd_data = wb_data_t'(delta_q);
            REG_THRESH0: rd_data = wb_data_t'(cfg.thresh[0]);
            REG_THRESH1: rd_data = wb_data_t'(cfg.thresh[1]);
            REG_COUNT0:  rd_data = wb_data_t'(cfg.count[0]);
            REG_COUNT1:  rd_data = wb_data_t'(cfg.count[1]);
            default:     rd_data = '0;
        endcase
    end

    // Read data held for the ack cycle
    always_ff @(posedge wbclk) begin
        if (access) begin
            dat_q <= rd_data;
        end
    end

    assign wb_ack_o = ack_q;
    assign wb_dat_o = dat_q;

    assign cfg.enable  = enable_q;
    assign cfg.restart = restart_q;
    assign cfg.target  = target_q;
    assign cfg.margin  = margin_q;
    assign cfg.delta   = delta_q;

endmodule

// File: l1_beam_trigger.sv
`include "l1_trigger_config.svh"

module l1_beam_trigger (
    input  logic                      wbclk,
    input  logic                      reset_delay,
    input  l1_trigger_pkg::sample_t   samples_i [`L1_NCHAN],
    input  l1_trigger_pkg::thresh_t   thresh_i  [`L1_NBEAMS],
    output l1_trigger_pkg::beam_vec_t trigger_o
);
    import l1_trigger_pkg::*;

    localparam int SUM_W = $bits(beam_sum_t);

    // Tap 0 is the input register, tap d holds the sample from d cycles earlier
    sample_t          sample_line_q [`L1_NCHAN][`L1_MAX_DELAY+1];
    beam_sum_t        beam_sum_d    [`L1_NBEAMS];
    beam_sum_t        beam_sum_q    [`L1_NBEAMS];
    logic [SUM_W-1:0] beam_mag      [`L1_NBEAMS];
    beam_vec_t        trig_q;

    // Cleared so the first taps after reset read zero
    always_ff @(posedge wbclk) begin
        if (!reset_delay) begin
            for (int c = 0; c < `L1_NCHAN; c++) begin
                for (int d = 0; d <= `L1_MAX_DELAY; d++) begin
                    sample_line_q[c][d] <= '0;
                end
            end
        end else begin
            for (int c = 0; c < `L1_NCHAN; c++) begin
                sample_line_q[c][0] <= samples_i[c];
                for (int d = 1; d <= `L1_MAX_DELAY; d++) begin
                    sample_line_q[c][d] <= sample_line_q[c][d-1];
                end
            end
        end
    end

    // Delay and sum, one tap per channel picked by the beam table
    always_comb begin
        for (int b = 0; b < `L1_NBEAMS; b++) begin
            beam_sum_d[b] = '0;
            for (int c = 0; c < `L1_NCHAN; c++) begin
                beam_sum_d[b] = beam_sum_d[b]
                              + beam_sum_t'(sample_line_q[c][BEAM_DELAY[b][c]]);
            end
        end
    end

    always_ff @(posedge wbclk) begin
        beam_sum_q <= beam_sum_d;
    end

    // Full negative scale still fits as unsigned
    always_comb begin
        for (int b = 0; b < `L1_NBEAMS; b++) begin
            beam_mag[b] = beam_sum_q[b][SUM_W-1] ? -beam_sum_q[b] : beam_sum_q[b];
        end
    end

    always_ff @(posedge wbclk) begin
        if (!reset_delay) begin
            trig_q <= '0;
        end else begin
            for (int b = 0; b < `L1_NBEAMS; b++) begin
                trig_q[b] <= (thresh_t'(beam_mag[b]) > thresh_i[b]);
            end
        end
    end

    assign trigger_o = trig_q;

endmodule

// File: l1_threshold_servo.sv
`include "l1_trigger_config.svh"

module l1_threshold_servo (
    input  logic                      wbclk,
    input  logic                      reset_delay,
    input  l1_trigger_pkg::beam_vec_t trigger_i,
    servo_cfg_if.servo                cfg
);
    import l1_trigger_pkg::*;

    localparam int TIMER_W = $clog2(`L1_TRIGGER_CLOCKS);
    localparam int COUNT_W = $bits(trig_count_t);
    localparam int THRESH_W = $bits(thresh_t);

    logic [TIMER_W-1:0]  timer_q;
    logic                period_end;
    trig_count_t         counter_q   [`L1_NBEAMS];
    trig_count_t         counter_nxt [`L1_NBEAMS];  // Includes this cycle's trigger
    trig_count_t         count_q     [`L1_NBEAMS];
    thresh_t             thresh_q    [`L1_NBEAMS];
    logic [THRESH_W:0]   thresh_up   [`L1_NBEAMS];  // One extra bit for overflow
    logic [COUNT_W:0]    upper_lim;
    trig_count_t         lower_lim;

    assign period_end = (timer_q == TIMER_W'(`L1_TRIGGER_CLOCKS - 1));

    assign upper_lim = {1'b0, cfg.target} + {1'b0, cfg.margin};
    assign lower_lim = (cfg.target >= cfg.margin) ? cfg.target - cfg.margin : '0;

    always_comb begin
        for (int b = 0; b < `L1_NBEAMS; b++) begin
            // Saturate instead of wrapping
            counter_nxt[b] = (counter_q[b] == '1) ? counter_q[b]
                                                  : counter_q[b] + trigger_i[b];
            thresh_up[b]   = {1'b0, thresh_q[b]} + {1'b0, cfg.delta};
        end
    end

    // Period timer and trigger counters
    always_ff @(posedge wbclk) begin
        if (!reset_delay || cfg.restart) begin
            timer_q <= '0;
            for (int b = 0; b < `L1_NBEAMS; b++) begin
                counter_q[b] <= '0;
                count_q[b]   <= '0;
            end
        end else begin
            timer_q <= period_end ? '0 : timer_q + 1'b1;
            for (int b = 0; b < `L1_NBEAMS; b++) begin
                if (period_end) begin
                    count_q[b]   <= counter_nxt[b];
                    counter_q[b] <= '0;
                end else begin
                    counter_q[b] <= counter_nxt[b];
                end
            end
        end
    end

    // Thresholds, bus loads only while stopped, steps only while running
    always_ff @(posedge wbclk) begin
        if (!reset_delay) begin
            for (int b = 0; b < `L1_NBEAMS; b++) begin
                thresh_q[b] <= thresh_t'(`L1_DEFAULT_THRESH);
            end
        end else begin
            for (int b = 0; b < `L1_NBEAMS; b++) begin
                if (!cfg.enable && cfg.thresh_wr[b]) begin
                    thresh_q[b] <= cfg.thresh_wdata;
                end else if (cfg.enable && period_end && !cfg.restart) begin
                    if ({1'b0, counter_nxt[b]} > upper_lim) begin
                        thresh_q[b] <= thresh_up[b][THRESH_W] ? '1
                                                              : thresh_up[b][THRESH_W-1:0];
                    end else if (counter_nxt[b] < lower_lim && thresh_q[b] >= cfg.delta) begin
                        thresh_q[b] <= thresh_q[b] - cfg.delta;
                    end
                end
            end
        end
    end

    assign cfg.thresh = thresh_q;
    assign cfg.count  = count_q;

endmodule

// File: l1_trigger_top.sv
`include "l1_trigger_config.svh"

module l1_trigger_top (
    input  logic                      wbclk,
    input  logic                      reset_delay,

    // Wishbone register port
    input  logic                      wb_cyc_i,
    input  logic                      wb_stb_i,
    input  logic                      wb_we_i,
    input  l1_regmap_pkg::wb_addr_t   wb_adr_i,
    input  l1_regmap_pkg::wb_data_t   wb_dat_i,
    output logic                      wb_ack_o,
    output l1_regmap_pkg::wb_data_t   wb_dat_o,

    // One sample per channel every clock
    input  l1_trigger_pkg::sample_t   samples_i [`L1_NCHAN],
    output l1_trigger_pkg::beam_vec_t trigger_o
);
    import l1_trigger_pkg::*;

    beam_vec_t beam_trig;

    servo_cfg_if cfg_if ();

    l1_wb_regs u_wb_regs (
        .wbclk       (wbclk),
        .reset_delay (reset_delay),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_o    (wb_ack_o),
        .wb_dat_o    (wb_dat_o),
        .cfg         (cfg_if.regs)
    );

    l1_beam_trigger u_beam_trigger (
        .wbclk       (wbclk),
        .reset_delay (reset_delay),
        .samples_i   (samples_i),
        .thresh_i    (cfg_if.thresh),  // Live servo thresholds
        .trigger_o   (beam_trig)
    );

    l1_threshold_servo u_threshold_servo (
        .wbclk       (wbclk),
        .reset_delay (reset_delay),
        .trigger_i   (beam_trig),
        .cfg         (cfg_if.servo)
    );

    assign trigger_o = beam_trig;

endmodule

// File: l1_trigger_chk.sv
module l1_trigger_chk (
    input logic                      wbclk,
    input logic                      reset_delay,
    input logic                      cyc_i,
    input logic                      stb_i,
    input logic                      ack_i,
    input l1_trigger_pkg::beam_vec_t trigger_i
);
    timeunit 1ns;
    timeprecision 100ps;

    ack_single: assert property (@(posedge wbclk) disable iff (!reset_delay)
        ack_i |=> !ack_i)
        else $error("ack high for two cycles in a row");

    // Ack only answers an active strobe
    ack_after_stb: assert property (@(posedge wbclk) disable iff (!reset_delay)
        $rose(ack_i) |-> $past(cyc_i && stb_i))
        else $error("ack without an active strobe");

    trig_in_reset: assert property (@(posedge wbclk)
        !reset_delay |=> trigger_i == '0)
        else $error("trigger during reset");

    // Pipeline still holds reset zeros for three edges
    trig_after_reset: assert property (@(posedge wbclk)
        $rose(reset_delay) |-> (trigger_i == '0) [*3])
        else $error("trigger too early after reset");

endmodule

bind l1_trigger_top l1_trigger_chk u_chk (
    .wbclk       (wbclk),
    .reset_delay (reset_delay),
    .cyc_i       (wb_cyc_i),
    .stb_i       (wb_stb_i),
    .ack_i       (wb_ack_o),
    .trigger_i   (trigger_o)
);

// File: tb_l1_trigger.sv
`include "l1_trigger_config.svh"

module tb_l1_trigger;
    timeunit 1ns;
    timeprecision 100ps;

    import l1_trigger_pkg::*;
    import l1_regmap_pkg::*;

    logic      wbclk = 1'b0;
    logic      reset_delay;
    logic      wb_cyc_i;
    logic      wb_stb_i;
    logic      wb_we_i;
    wb_addr_t  wb_adr_i;
    wb_data_t  wb_dat_i;
    logic      wb_ack_o;
    wb_data_t  wb_dat_o;
    sample_t   samples_i [`L1_NCHAN];
    beam_vec_t trigger_o;

    int          hist [7][`L1_NCHAN];     // Sampled inputs with row 0 newest
    thresh_t     exp_thresh [`L1_NBEAMS];
    logic [31:0] lfsr = 32'hb0be_3382;
    bit          check_beams = 1'b0;
    int          n_checks = 0;
    int          n_errors = 0;

    l1_trigger_top UUT (.*);

    always #5 wbclk = ~wbclk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic int unsigned random_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // Sum of delayed taps with beam 1 adding one cycle every two channels
    function automatic bit expected_trigger(input int b);
        int sum;
        sum = 0;
        for (int c = 0; c < `L1_NCHAN; c++) begin
            sum += hist[3 + ((b == 1) ? c / 2 : 0)][c];
        end
        return ((sum < 0) ? -sum : sum) > int'(exp_thresh[b]);
    endfunction

    // Trigger seen at this point was computed from samples taken three edges back
    always @(negedge wbclk) begin
        for (int d = 6; d > 0; d--) begin
            hist[d] = hist[d-1];
        end
        for (int c = 0; c < `L1_NCHAN; c++) begin
            hist[0][c] = reset_delay ? samples_i[c] : 0;  // Delay lines hold zero in reset
        end
        if (check_beams) begin
            for (int b = 0; b < `L1_NBEAMS; b++) begin
                n_checks++;
                assert (trigger_o[b] === expected_trigger(b)) else begin
                    n_errors++;
                    $display("mismatch trigger_o[%0d]: got %h expected %h",
                             b, trigger_o[b], expected_trigger(b));
                end
            end
        end
    end

    task automatic finish_run();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge wbclk);
        end
        #1;
    endtask

    task automatic drive_samples(input sample_t v);
        foreach (samples_i[c]) begin
            samples_i[c] = v;
        end
    endtask

    task automatic bus_cycle(input reg_offset_t off, input bit we, input wb_data_t wdata,
                             output wb_data_t rdata);
        int n;
        wait_cycles(1);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = wb_addr_t'({off, 2'b00});
        wb_dat_i = wdata;
        n = 0;
        do begin
            wait_cycles(1);
            n++;
        end while (!wb_ack_o && n < 20);
        rdata    = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        if (!wb_ack_o) begin
            n_errors++;
            $display("no ack within 20 cycles for register %0d", off);
            finish_run();
        end
    endtask

    task automatic write_reg(input reg_offset_t off, input wb_data_t data);
        wb_data_t unused;
        bus_cycle(off, 1'b1, data, unused);
    endtask

    task automatic check_reg(input reg_offset_t off, input wb_data_t exp, input string name);
        wb_data_t got;
        bus_cycle(off, 1'b0, '0, got);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Servo moves a threshold one way only and in whole steps of delta
    task automatic verify_step(input int b, input wb_data_t got, input wb_data_t prev,
                               input bit up);
        int diff;
        bit ok;
        diff = int'(got) - int'(prev);
        if (up) begin
            ok = diff > 0 && diff % `L1_DEFAULT_DELTA == 0;
        end else if (prev >= `L1_DEFAULT_DELTA) begin
            ok = diff < 0 && diff % `L1_DEFAULT_DELTA == 0;
        end else begin
            ok = diff == 0;  // Held once below delta
        end
        n_checks++;
        assert (ok) else begin
            n_errors++;
            $display("mismatch thresh%0d: got %h after %h", b, got, prev);
        end
    endtask

    // At least one period end between calls
    task automatic servo_round(input bit up, input wb_data_t exp_count,
                               inout wb_data_t p0, inout wb_data_t p1);
        wb_data_t t0;
        wb_data_t t1;
        wait_cycles(`L1_TRIGGER_CLOCKS + 4);
        check_reg(REG_COUNT0, exp_count, "count0");
        check_reg(REG_COUNT1, exp_count, "count1");
        bus_cycle(REG_THRESH0, 1'b0, '0, t0);
        bus_cycle(REG_THRESH1, 1'b0, '0, t1);
        verify_step(0, t0, p0, up);
        verify_step(1, t1, p1, up);
        p0 = t0;
        p1 = t1;
    endtask

    initial begin
        wb_data_t p0;
        wb_data_t p1;
        bit       pulse;
        reset_delay = 1'b0;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        wb_we_i     = 1'b0;
        wb_adr_i    = '0;
        wb_dat_i    = '0;
        drive_samples(sample_t'(12'h7ff));  // Kept out of the delay lines by reset
        exp_thresh  = '{default: thresh_t'(`L1_DEFAULT_THRESH)};
        wait_cycles(16);
        reset_delay = 1'b1;
        drive_samples('0);
        check_beams = 1'b1;  // Zero input keeps triggers low

        check_reg(REG_TARGET, `L1_DEFAULT_TARGET, "target");
        check_reg(REG_MARGIN, `L1_DEFAULT_MARGIN, "margin");
        check_reg(REG_DELTA, `L1_DEFAULT_DELTA, "delta");
        check_reg(REG_THRESH0, `L1_DEFAULT_THRESH, "thresh0");
        check_reg(REG_THRESH1, `L1_DEFAULT_THRESH, "thresh1");
        check_reg(REG_COUNT0, 0, "count0");
        check_reg(REG_COUNT1, 0, "count1");

        write_reg(REG_TARGET, 12);
        write_reg(REG_MARGIN, 3);
        write_reg(REG_DELTA, 40);
        write_reg(REG_THRESH0, 1234);
        write_reg(REG_THRESH1, 4321);
        write_reg(REG_COUNT0, 32'h55);  // Read only
        write_reg(REG_COUNT1, 32'haa);
        check_reg(REG_TARGET, 12, "target");
        check_reg(REG_MARGIN, 3, "margin");
        check_reg(REG_DELTA, 40, "delta");
        check_reg(REG_THRESH0, 1234, "thresh0");
        check_reg(REG_THRESH1, 4321, "thresh1");
        check_reg(REG_COUNT0, 0, "count0");
        check_reg(REG_COUNT1, 0, "count1");
        write_reg(REG_TARGET, `L1_DEFAULT_TARGET);
        write_reg(REG_MARGIN, `L1_DEFAULT_MARGIN);
        write_reg(REG_DELTA, `L1_DEFAULT_DELTA);

        // Random samples with the occasional full-scale pulse on all channels
        exp_thresh[0] = 3000;
        exp_thresh[1] = 6000;
        write_reg(REG_THRESH0, exp_thresh[0]);
        write_reg(REG_THRESH1, exp_thresh[1]);
        repeat (400) begin
            pulse = (random_bits(4) == 0);
            foreach (samples_i[c]) begin
                samples_i[c] = pulse ? sample_t'(12'h7ff) : sample_t'(random_bits(`L1_SAMPLE_W));
            end
            wait_cycles(1);
        end
        drive_samples('0);
        wait_cycles(4);
        check_beams = 1'b0;

        write_reg(REG_THRESH0, `L1_DEFAULT_THRESH);
        write_reg(REG_THRESH1, `L1_DEFAULT_THRESH);
        drive_samples(sample_t'(12'h7ff));
        wait_cycles(4);
        write_reg(REG_CTRL, 32'h3);  // Enable and restart
        p0 = `L1_DEFAULT_THRESH;
        p1 = `L1_DEFAULT_THRESH;
        repeat (3) servo_round(1'b1, `L1_TRIGGER_CLOCKS, p0, p1);

        drive_samples('0);
        wait_cycles(4);
        write_reg(REG_CTRL, 32'h3);
        bus_cycle(REG_THRESH0, 1'b0, '0, p0);
        bus_cycle(REG_THRESH1, 1'b0, '0, p1);
        repeat (20) servo_round(1'b0, 0, p0, p1);
        check_reg(REG_THRESH0, 0, "thresh0");
        check_reg(REG_THRESH1, 0, "thresh1");

        write_reg(REG_CTRL, 32'h0);
        write_reg(REG_THRESH0, 1000);
        write_reg(REG_THRESH1, 2000);
        drive_samples(sample_t'(12'h7ff));
        wait_cycles(2 * `L1_TRIGGER_CLOCKS + 8);  // One whole period at full scale
        check_reg(REG_COUNT0, `L1_TRIGGER_CLOCKS, "count0");
        check_reg(REG_COUNT1, `L1_TRIGGER_CLOCKS, "count1");
        write_reg(REG_CTRL, 32'h2);
        check_reg(REG_COUNT0, 0, "count0");
        check_reg(REG_COUNT1, 0, "count1");
        check_reg(REG_THRESH0, 1000, "thresh0");
        check_reg(REG_THRESH1, 2000, "thresh1");
        finish_run();
    end

endmodule

// File: filelist.f
+incdir+.
l1_trigger_pkg.sv
l1_regmap_pkg.sv
servo_cfg_if.sv
l1_wb_regs.sv
l1_beam_trigger.sv
l1_threshold_servo.sv
l1_trigger_top.sv
l1_trigger_chk.sv
tb_l1_trigger.sv

// File: Bender.yml
package:
  name: l1_trigger

sources:
  - include_dirs:
      - .
    files:
      - l1_trigger_pkg.sv
      - l1_regmap_pkg.sv
      - servo_cfg_if.sv
      - l1_wb_regs.sv
      - l1_beam_trigger.sv
      - l1_threshold_servo.sv
      - l1_trigger_top.sv
      - target: test
        files:
          - l1_trigger_chk.sv
          - tb_l1_trigger.sv
